//--- Makefile
TOP := tb_ahb_lite_matrix

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard *.sv)
	verilator --binary --timing --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee run.log
	grep -q "all tests passed" run.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir run.log

//--- ahb_decoder.sv
`timescale 1ns/1ns

module ahb_decoder (
    input  logic [31:0]             haddr,
    output soc_map_pkg::slave_sel_t hsel
);

    logic ram0_hit;
    logic ram1_hit;
    logic gpio_hit;
    logic timer_hit;

    assign ram0_hit  = haddr[31:28] == soc_map_pkg::RAM0_BASE[31:28];
    assign ram1_hit  = haddr[31:28] == soc_map_pkg::RAM1_BASE[31:28];
    assign gpio_hit  = haddr[31:12] == soc_map_pkg::GPIO_BASE[31:12];
    assign timer_hit = haddr[31:12] == soc_map_pkg::TIMER_BASE[31:12];

    // The regions do not overlap, but the chain keeps the select one-hot regardless.
    always_comb begin
        hsel = '0;
        if (ram0_hit) begin
            hsel[soc_map_pkg::SEL_RAM0] = 1'b1;
        end else if (ram1_hit) begin
            hsel[soc_map_pkg::SEL_RAM1] = 1'b1;
        end else if (gpio_hit) begin
            hsel[soc_map_pkg::SEL_GPIO] = 1'b1;
        end else if (timer_hit) begin
            hsel[soc_map_pkg::SEL_TIMER] = 1'b1;
        end else begin
            hsel[soc_map_pkg::SEL_DEFAULT] = 1'b1; // Unmapped space.
        end
    end

endmodule

//--- ahb_default_slave.sv
`timescale 1ns/1ns

module ahb_default_slave (
    input  logic               HCLK,
    input  logic               rst_n,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::htrans_t   htrans,
    output ahb_pkg::ahb_resp_t resp
);

    typedef enum logic [1:0] {
        IDLE,
        ERR_FIRST,
        ERR_SECOND
    } state_t;

    state_t state_q;
    state_t state_next;
    logic   accept;

    assign accept = hsel && hready && ahb_pkg::trans_active(htrans);

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE:       if (accept) state_next = ERR_FIRST;
            ERR_FIRST:  state_next = ERR_SECOND; // Stalls the bus for one cycle.
            ERR_SECOND: state_next = accept ? ERR_FIRST : IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // ERROR is held for both cycles; hready only rises in the second.
    assign resp.hrdata = 32'h0;
    assign resp.hready = state_q != ERR_FIRST;
    assign resp.hresp  = (state_q == IDLE) ? ahb_pkg::HRESP_OKAY : ahb_pkg::HRESP_ERROR;

endmodule

//--- ahb_gpio_slave.sv
`timescale 1ns/1ns

module ahb_gpio_slave (
    input  logic                               HCLK,
    input  logic                               rst_n,
    input  logic                               hsel,
    input  logic                               hready,
    input  ahb_pkg::ahb_req_t                  req,
    input  logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_in,
    output logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_out,
    output ahb_pkg::ahb_resp_t                 resp
);

    logic [soc_map_pkg::GPIO_WIDTH-1:0] in_meta;
    logic [soc_map_pkg::GPIO_WIDTH-1:0] in_sync;
    logic [soc_map_pkg::GPIO_WIDTH-1:0] out_q;
    logic [9:0]                         ofs_q;
    logic                               write_q;
    logic                               accept;

    assign accept = hsel && hready && ahb_pkg::trans_active(req.htrans);

    always_ff @(posedge HCLK) begin
        if (accept) begin
            ofs_q <= req.haddr[11:2]; // Word offset within the page.
        end
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
            out_q   <= '0;
            write_q <= 1'b0;
        end else begin
            in_meta <= gpio_in; // Pins are asynchronous to HCLK.
            in_sync <= in_meta;
            if (hready) begin
                write_q <= accept && req.hwrite;
            end
            if (write_q && hready && ofs_q == soc_map_pkg::GPIO_OUT_OFS[11:2]) begin
                out_q <= req.hwdata[soc_map_pkg::GPIO_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        resp.hready = 1'b1;
        resp.hresp  = ahb_pkg::HRESP_OKAY;
        case (ofs_q)
            soc_map_pkg::GPIO_IN_OFS[11:2]:
                resp.hrdata = {{(32 - soc_map_pkg::GPIO_WIDTH){1'b0}}, in_sync};
            soc_map_pkg::GPIO_OUT_OFS[11:2]:
                resp.hrdata = {{(32 - soc_map_pkg::GPIO_WIDTH){1'b0}}, out_q};
            default:
                resp.hrdata = 32'h0;
        endcase
    end

    assign gpio_out = out_q;

endmodule

//--- ahb_lite_matrix.sv
`timescale 1ns/1ns

module ahb_lite_matrix (
    input  logic                               HCLK,
    input  logic                               rst_n,
    input  ahb_pkg::ahb_req_t                  bus_req,
    output ahb_pkg::ahb_resp_t                 bus_resp,
    input  logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_in,
    output logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_out,
    output logic                               timer_irq
);

    soc_map_pkg::slave_sel_t hsel;
    ahb_pkg::ahb_resp_t      ram0_resp;
    ahb_pkg::ahb_resp_t      ram1_resp;
    ahb_pkg::ahb_resp_t      gpio_resp;
    ahb_pkg::ahb_resp_t      timer_resp;
    ahb_pkg::ahb_resp_t      dflt_resp;

    ahb_decoder decoder_i (.haddr(bus_req.haddr), .hsel(hsel));

    ahb_ram_slave #(.ADDR_WIDTH(soc_map_pkg::RAM0_ADDR_WIDTH)) ram0_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel[soc_map_pkg::SEL_RAM0]),
        .hready(bus_resp.hready), .req(bus_req), .resp(ram0_resp)
    );

    ahb_ram_slave #(.ADDR_WIDTH(soc_map_pkg::RAM1_ADDR_WIDTH)) ram1_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel[soc_map_pkg::SEL_RAM1]),
        .hready(bus_resp.hready), .req(bus_req), .resp(ram1_resp)
    );

    ahb_gpio_slave gpio_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel[soc_map_pkg::SEL_GPIO]),
        .hready(bus_resp.hready), .req(bus_req), .gpio_in(gpio_in),
        .gpio_out(gpio_out), .resp(gpio_resp)
    );

    ahb_timer_slave timer_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel[soc_map_pkg::SEL_TIMER]),
        .hready(bus_resp.hready), .req(bus_req), .resp(timer_resp),
        .timer_irq(timer_irq)
    );

    ahb_default_slave dflt_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel[soc_map_pkg::SEL_DEFAULT]),
        .hready(bus_resp.hready), .htrans(bus_req.htrans), .resp(dflt_resp)
    );

    // The mux output is also the global hready seen by every slave.
    ahb_resp_mux resp_mux_i (
        .HCLK(HCLK), .rst_n(rst_n), .hsel(hsel), .htrans(bus_req.htrans),
        .ram0_resp(ram0_resp), .ram1_resp(ram1_resp), .gpio_resp(gpio_resp),
        .timer_resp(timer_resp), .dflt_resp(dflt_resp), .bus_resp(bus_resp)
    );

endmodule

//--- ahb_pkg.sv
package ahb_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_t;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_t;

    // Master request. hwdata belongs to the previous address phase.
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hsize_t      hsize;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        hresp_t      hresp;
    } ahb_resp_t;

    localparam ahb_resp_t RESP_IDLE = '{hrdata: 32'h0, hready: 1'b1, hresp: HRESP_OKAY};

    // BUSY and IDLE carry no transfer.
    function automatic logic trans_active(input htrans_t htrans);
        return (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
    endfunction

endpackage

//--- ahb_ram_slave.sv
`timescale 1ns/1ns

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = 14
) (
    input  logic               HCLK,
    input  logic               rst_n,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::ahb_req_t  req,
    output ahb_pkg::ahb_resp_t resp
);

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [31:0]           mem [WORDS];
    logic [ADDR_WIDTH-3:0] waddr_q;
    logic [1:0]            ofs_q;
    ahb_pkg::hsize_t       size_q;
    logic                  write_q;
    logic [3:0]            be;
    logic                  accept;

    assign accept = hsel && hready && ahb_pkg::trans_active(req.htrans);

    // Higher address bits are dropped here, which gives the aliasing of the region.
    always_ff @(posedge HCLK) begin
        if (accept) begin
            waddr_q <= req.haddr[ADDR_WIDTH-1:2];
            ofs_q   <= req.haddr[1:0];
            size_q  <= req.hsize;
        end
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            write_q <= 1'b0;
        end else if (hready) begin
            write_q <= accept && req.hwrite;
        end
    end

    // Lane enables for little-endian byte and halfword stores.
    always_comb begin
        case (size_q)
            ahb_pkg::HSIZE_BYTE: be = 4'b0001 << ofs_q;
            ahb_pkg::HSIZE_HALF: be = ofs_q[1] ? 4'b1100 : 4'b0011;
            default:             be = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (write_q && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[waddr_q][8*i +: 8] <= req.hwdata[8*i +: 8];
                end
            end
        end
    end

    // The whole word goes back and the master takes its lane.
    assign resp.hrdata = mem[waddr_q];
    assign resp.hready = 1'b1;
    assign resp.hresp  = ahb_pkg::HRESP_OKAY;

endmodule

//--- ahb_resp_mux.sv
`timescale 1ns/1ns

module ahb_resp_mux (
    input  logic                    HCLK,
    input  logic                    rst_n,
    input  soc_map_pkg::slave_sel_t hsel,
    input  ahb_pkg::htrans_t        htrans,
    input  ahb_pkg::ahb_resp_t      ram0_resp,
    input  ahb_pkg::ahb_resp_t      ram1_resp,
    input  ahb_pkg::ahb_resp_t      gpio_resp,
    input  ahb_pkg::ahb_resp_t      timer_resp,
    input  ahb_pkg::ahb_resp_t      dflt_resp,
    output ahb_pkg::ahb_resp_t      bus_resp
);

    soc_map_pkg::slave_sel_t dsel; // Owner of the current data phase.

    // The select only advances when the current data phase completes.
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            dsel <= '0;
        end else if (bus_resp.hready) begin
            dsel <= ahb_pkg::trans_active(htrans) ? hsel : '0;
        end
    end

    always_comb begin
        if (dsel[soc_map_pkg::SEL_RAM0]) begin
            bus_resp = ram0_resp;
        end else if (dsel[soc_map_pkg::SEL_RAM1]) begin
            bus_resp = ram1_resp;
        end else if (dsel[soc_map_pkg::SEL_GPIO]) begin
            bus_resp = gpio_resp;
        end else if (dsel[soc_map_pkg::SEL_TIMER]) begin
            bus_resp = timer_resp;
        end else if (dsel[soc_map_pkg::SEL_DEFAULT]) begin
            bus_resp = dflt_resp;
        end else begin
            bus_resp = ahb_pkg::RESP_IDLE; // Nothing pending.
        end
    end

endmodule

//--- ahb_timer_slave.sv
`timescale 1ns/1ns

module ahb_timer_slave (
    input  logic               HCLK,
    input  logic               rst_n,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::ahb_req_t  req,
    output ahb_pkg::ahb_resp_t resp,
    output logic               timer_irq
);

    logic [9:0]  ofs_q;
    logic        write_q;
    logic [31:0] count_q;
    logic [31:0] count_next;
    logic [31:0] cmp_q;
    logic        match_q;
    logic        wr_en;
    logic        accept;

    assign accept = hsel && hready && ahb_pkg::trans_active(req.htrans);
    assign wr_en  = write_q && hready;

    always_ff @(posedge HCLK) begin
        if (accept) begin
            ofs_q <= req.haddr[11:2];
        end
    end

    // A bus write to the count overrides the increment for that cycle.
    always_comb begin
        count_next = count_q + 32'd1;
        if (wr_en && ofs_q == soc_map_pkg::TIMER_COUNT_OFS[11:2]) begin
            count_next = req.hwdata;
        end
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            write_q <= 1'b0;
            count_q <= 32'h0;
            cmp_q   <= 32'h0;
            match_q <= 1'b0;
        end else begin
            count_q <= count_next;
            if (hready) begin
                write_q <= accept && req.hwrite;
            end
            if (wr_en && ofs_q == soc_map_pkg::TIMER_CMP_OFS[11:2]) begin
                cmp_q <= req.hwdata;
            end
            // Match is taken as the count steps onto the compare value, so a new hit wins over a clear.
            if (count_next == cmp_q) begin
                match_q <= 1'b1;
            end else if (wr_en && ofs_q == soc_map_pkg::TIMER_STAT_OFS[11:2] && req.hwdata[0]) begin
                match_q <= 1'b0;
            end
        end
    end

    always_comb begin
        resp.hready = 1'b1;
        resp.hresp  = ahb_pkg::HRESP_OKAY;
        case (ofs_q)
            soc_map_pkg::TIMER_COUNT_OFS[11:2]: resp.hrdata = count_q;
            soc_map_pkg::TIMER_CMP_OFS[11:2]:   resp.hrdata = cmp_q;
            soc_map_pkg::TIMER_STAT_OFS[11:2]:  resp.hrdata = {31'h0, match_q};
            default:                            resp.hrdata = 32'h0;
        endcase
    end

    assign timer_irq = match_q;

endmodule

//--- build.f
ahb_pkg.sv
soc_map_pkg.sv
ahb_decoder.sv
ahb_resp_mux.sv
ahb_ram_slave.sv
ahb_gpio_slave.sv
ahb_timer_slave.sv
ahb_default_slave.sv
ahb_lite_matrix.sv
tb_ahb_lite_matrix.sv

//--- soc_map_pkg.sv
package soc_map_pkg;

    localparam int NUM_SLAVES  = 5;

    localparam int SEL_RAM0    = 0;
    localparam int SEL_RAM1    = 1;
    localparam int SEL_GPIO    = 2;
    localparam int SEL_TIMER   = 3;
    localparam int SEL_DEFAULT = 4;

    typedef logic [NUM_SLAVES-1:0] slave_sel_t;

    // RAM regions decode on the top nibble only, so each RAM repeats through its region.
    localparam logic [31:0] RAM0_BASE       = 32'h0000_0000;
    localparam int          RAM0_ADDR_WIDTH = 14;
    localparam logic [31:0] RAM1_BASE       = 32'h2000_0000;
    localparam int          RAM1_ADDR_WIDTH = 12;

    localparam logic [31:0] GPIO_BASE  = 32'h4000_0000; // One 4 KB page each.
    localparam logic [31:0] TIMER_BASE = 32'h4000_1000;

    localparam logic [11:0] GPIO_IN_OFS     = 12'h000;
    localparam logic [11:0] GPIO_OUT_OFS    = 12'h004;
    localparam logic [11:0] TIMER_COUNT_OFS = 12'h000;
    localparam logic [11:0] TIMER_CMP_OFS   = 12'h004;
    localparam logic [11:0] TIMER_STAT_OFS  = 12'h008;

    localparam int GPIO_WIDTH = 16;

endpackage

//--- tb_ahb_lite_matrix.sv
`timescale 1ns/1ns

module tb_ahb_lite_matrix;

    logic                               HCLK;
    logic                               rst_n;
    ahb_pkg::ahb_req_t                  bus_req;
    ahb_pkg::ahb_resp_t                 bus_resp;
    logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_in;
    logic [soc_map_pkg::GPIO_WIDTH-1:0] gpio_out;
    logic                               timer_irq;

    ahb_lite_matrix ahb_lite_matrix_i (
        .HCLK(HCLK), .rst_n(rst_n), .bus_req(bus_req), .bus_resp(bus_resp),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .timer_irq(timer_irq)
    );

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    function automatic logic [31:0] periph_addr(input logic [31:0] base, input logic [11:0] ofs);
        return base | {20'h0, ofs};
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input ahb_pkg::hresp_t expected,
                              input ahb_pkg::hresp_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %s, got %s", name, expected.name(), actual.name());
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, got %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_range(input string name, input logic [31:0] low,
                               input logic [31:0] high, input logic [31:0] actual);
        if ($isunknown(actual) || actual < low || actual > high) begin
            $display("error %s: expected %h to %h, got %h", name, low, high, actual);
            abort_run();
        end
    endtask

    // Called at a falling edge; returns at the falling edge before the completing rise.
    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (bus_resp.hready !== 1'b1) begin
            @(negedge HCLK);
            cycles++;
            if (cycles > 20) begin
                $display("timeout: hready stayed low for 20 cycles in the %s", what);
                abort_run();
            end
        end
    endtask

    task automatic address_phase(input logic [31:0] addr, input ahb_pkg::hsize_t size,
                                 input logic write);
        @(negedge HCLK);
        bus_req.haddr  = addr;
        bus_req.htrans = ahb_pkg::HTRANS_NONSEQ;
        bus_req.hsize  = size;
        bus_req.hwrite = write;
        wait_ready("address phase");
    endtask

    task automatic ahb_write(input logic [31:0] addr, input ahb_pkg::hsize_t size,
                             input logic [31:0] data);
        address_phase(addr, size, 1'b1);
        @(negedge HCLK);
        bus_req.htrans = ahb_pkg::HTRANS_IDLE;
        bus_req.hwdata = data; // Data follows its address by one cycle.
        wait_ready("write data phase");
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                            output ahb_pkg::hresp_t resp);
        address_phase(addr, ahb_pkg::HSIZE_WORD, 1'b0);
        @(negedge HCLK);
        bus_req.htrans = ahb_pkg::HTRANS_IDLE;
        wait_ready("read data phase");
        data = bus_resp.hrdata;
        resp = bus_resp.hresp;
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr,
                               input logic [31:0] expected);
        logic [31:0]     data;
        ahb_pkg::hresp_t resp;
        ahb_read(addr, data, resp);
        check_resp(name, ahb_pkg::HRESP_OKAY, resp);
        check_data(name, expected, data);
    endtask

    task automatic reset_state();
        check_flag("reset hready", 1'b1, bus_resp.hready);
        check_resp("reset hresp", ahb_pkg::HRESP_OKAY, bus_resp.hresp);
        check_data("reset gpio_out", 32'h0, 32'(gpio_out));
        check_flag("reset timer_irq", 1'b0, timer_irq);
        read_expect("reset timer compare",
                    periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_CMP_OFS), 32'h0);
    endtask

    task automatic ram_readback();
        logic [31:0] wr_addr [7];
        logic [31:0] rd_addr [7];
        logic [31:0] wdata [7];
        wr_addr = '{32'h0000_0000, 32'h0000_0004, 32'h0000_2A40, 32'h0000_3FFC,
                    32'h2000_0000, 32'h2000_0FFC, 32'h2000_1010};
        // The last entry is read through the 4 KB wrap of RAM1.
        rd_addr = '{32'h0000_0000, 32'h0000_0004, 32'h0000_2A40, 32'h0000_3FFC,
                    32'h2000_0000, 32'h2000_0FFC, 32'h2000_0010};
        foreach (wdata[i]) begin
            wdata[i] = $urandom;
            ahb_write(wr_addr[i], ahb_pkg::HSIZE_WORD, wdata[i]);
        end
        foreach (wdata[i]) begin
            read_expect($sformatf("ram word %0d", i), rd_addr[i], wdata[i]);
        end
        read_expect("ram1 alias of top word", 32'h2000_3FFC, wdata[5]);
        ahb_write(32'h0000_0100, ahb_pkg::HSIZE_WORD, 32'h1122_3344);
        ahb_write(32'h0000_0102, ahb_pkg::HSIZE_BYTE, 32'hA5A5_A5A5);
        read_expect("ram byte lane 2", 32'h0000_0100, 32'h11A5_3344);
        ahb_write(32'h0000_0100, ahb_pkg::HSIZE_HALF, 32'hDEAD_BEEF);
        read_expect("ram low halfword", 32'h0000_0100, 32'h11A5_BEEF);
        ahb_write(32'h0000_0102, ahb_pkg::HSIZE_HALF, 32'hCAFE_1234);
        read_expect("ram high halfword", 32'h0000_0100, 32'hCAFE_BEEF);
        ahb_write(32'h0000_0101, ahb_pkg::HSIZE_BYTE, 32'h7777_7777);
        read_expect("ram byte lane 1", 32'h0000_0100, 32'hCAFE_77EF);
    endtask

    task automatic gpio_ports();
        logic [31:0]     value;
        logic [31:0]     pins;
        logic [31:0]     data;
        ahb_pkg::hresp_t resp;
        int              polls;
        value = $urandom & 32'h0000_FFFF;
        ahb_write(periph_addr(soc_map_pkg::GPIO_BASE, soc_map_pkg::GPIO_OUT_OFS),
                  ahb_pkg::HSIZE_WORD, value);
        read_expect("gpio output register",
                    periph_addr(soc_map_pkg::GPIO_BASE, soc_map_pkg::GPIO_OUT_OFS), value);
        check_data("gpio_out pins", value, 32'(gpio_out));
        pins    = $urandom & 32'h0000_FFFF;
        gpio_in = pins[soc_map_pkg::GPIO_WIDTH-1:0];
        polls   = 0;
        ahb_read(periph_addr(soc_map_pkg::GPIO_BASE, soc_map_pkg::GPIO_IN_OFS), data, resp);
        while (data !== pins) begin // The pins pass a two-flop synchronizer first.
            polls++;
            if (polls > 20) begin
                $display("timeout: the gpio_in value never showed in the input register");
                abort_run();
            end
            ahb_read(periph_addr(soc_map_pkg::GPIO_BASE, soc_map_pkg::GPIO_IN_OFS), data, resp);
        end
        check_resp("gpio input register", ahb_pkg::HRESP_OKAY, resp);
    endtask

    task automatic timer_match();
        logic [31:0]     load;
        logic [31:0]     data;
        ahb_pkg::hresp_t resp;
        int              cycles;
        load = $urandom & 32'h7FFF_FFFF;
        ahb_write(periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_COUNT_OFS),
                  ahb_pkg::HSIZE_WORD, load);
        ahb_read(periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_COUNT_OFS), data, resp);
        check_resp("timer count read", ahb_pkg::HRESP_OKAY, resp);
        check_range("timer count after load", load, load + 32'd10, data);
        ahb_write(periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_CMP_OFS),
                  ahb_pkg::HSIZE_WORD, load + 32'd40);
        @(negedge HCLK);
        check_flag("timer_irq before match", 1'b0, timer_irq); // Count is still far below.
        cycles = 0;
        while (timer_irq !== 1'b1) begin
            @(negedge HCLK);
            cycles++;
            if (cycles > 100) begin
                $display("timeout: timer_irq did not rise within 100 cycles");
                abort_run();
            end
        end
        read_expect("timer status after match",
                    periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_STAT_OFS), 32'h1);
        ahb_write(periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_STAT_OFS),
                  ahb_pkg::HSIZE_WORD, 32'h1);
        @(negedge HCLK);
        check_flag("timer_irq after clear", 1'b0, timer_irq);
        read_expect("timer status after clear",
                    periph_addr(soc_map_pkg::TIMER_BASE, soc_map_pkg::TIMER_STAT_OFS), 32'h0);
    endtask

    task automatic unmapped_access();
        logic [31:0] value;
        value = $urandom;
        ahb_write(32'h0000_0008, ahb_pkg::HSIZE_WORD, value);
        address_phase(32'h8000_0000, ahb_pkg::HSIZE_WORD, 1'b0);
        @(negedge HCLK);
        bus_req.htrans = ahb_pkg::HTRANS_IDLE;
        check_flag("unmapped first cycle hready", 1'b0, bus_resp.hready);
        check_resp("unmapped first cycle hresp", ahb_pkg::HRESP_ERROR, bus_resp.hresp);
        @(negedge HCLK);
        check_flag("unmapped second cycle hready", 1'b1, bus_resp.hready);
        check_resp("unmapped second cycle hresp", ahb_pkg::HRESP_ERROR, bus_resp.hresp);
        read_expect("ram read after error", 32'h0000_0008, value);
    endtask

    initial begin
        rst_n   = 1'b0;
        bus_req = '0;
        gpio_in = '0;
        void'($urandom(32'h3313));
        repeat (16) @(posedge HCLK);
        @(negedge HCLK);
        rst_n = 1'b1;
        reset_state();
        ram_readback();
        gpio_ports();
        timer_match();
        unmapped_access();
        $display("all tests passed");
        $finish;
    end

endmodule
